// ==== hdl/fc_pkg.sv ====
package fc_pkg;

  // Bus widths
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Interrupt lines toward the core
  localparam int unsigned NumIrq     = 32;
  localparam int unsigned IrqIdWidth = 5;

  // AXI response codes
  localparam logic [1:0] AxiRespOkay   = 2'b00;
  localparam logic [1:0] AxiRespSlvErr = 2'b10;

  // Core data port, request side
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [StrbWidth-1:0] be;
    logic [DataWidth-1:0] wdata;
  } obi_req_t;

  // Core data port, response side
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } obi_rsp_t;

  // AXI4-Lite master outputs
  typedef struct packed {
    logic                 aw_valid;
    logic [AddrWidth-1:0] aw_addr;
    logic                 w_valid;
    logic [DataWidth-1:0] w_data;
    logic [StrbWidth-1:0] w_strb;
    logic                 b_ready;
    logic                 ar_valid;
    logic [AddrWidth-1:0] ar_addr;
    logic                 r_ready;
  } axil_req_t;

  // AXI4-Lite slave answers
  typedef struct packed {
    logic                 aw_ready;
    logic                 w_ready;
    logic                 b_valid;
    logic [1:0]           b_resp;
    logic                 ar_ready;
    logic                 r_valid;
    logic [DataWidth-1:0] r_data;
    logic [1:0]           r_resp;
  } axil_rsp_t;

endpackage

// ==== hdl/fc_buffer.sv ====
`timescale 1ns/1ps

module fc_buffer #(
  parameter type         payload_t = logic,
  parameter int unsigned BufDepth  = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     valid_o
);

  localparam int unsigned PtrWidth = (BufDepth > 1) ? $clog2(BufDepth) : 1;
  localparam int unsigned CntWidth = $clog2(BufDepth + 1);

  payload_t            mem_q [BufDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push;
  logic                do_pop;

  assign full_o  = (count_q == CntWidth'(BufDepth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  // A full buffer still takes a push when the head leaves in the same cycle
  assign do_pop  = pop_i & valid_o;
  assign do_push = push_i & (~full_o | do_pop);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(BufDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(BufDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== hdl/fc_irq_ctrl.sv ====
`timescale 1ns/1ps

module fc_irq_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [fc_pkg::NumIrq-1:0]     events_i,
  input  logic                          irq_ack_i,
  input  logic [fc_pkg::IrqIdWidth-1:0] irq_ack_id_i,
  output logic                          irq_req_o,
  output logic [fc_pkg::IrqIdWidth-1:0] irq_id_o
);

  import fc_pkg::*;

  logic [NumIrq-1:0] pending_q;
  logic [NumIrq-1:0] pending_d;

  //**************************************************
  // Pending register
  //**************************************************

  // Acknowledge clear beats a new event on the same line
  always_comb begin
    for (int i = 0; i < NumIrq; i++) begin
      if (irq_ack_i && (irq_ack_id_i == IrqIdWidth'(i))) begin
        pending_d[i] = 1'b0;
      end else begin
        pending_d[i] = pending_q[i] | events_i[i];
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  //**************************************************
  // Lowest index select
  //**************************************************

  // Scan downward so the lowest pending bit is written last
  always_comb begin
    irq_id_o = '0;
    for (int i = NumIrq - 1; i >= 0; i--) begin
      if (pending_q[i]) begin
        irq_id_o = IrqIdWidth'(i);
      end
    end
  end

  assign irq_req_o = |pending_q;

endmodule

// ==== hdl/fc_obi_axil_bridge.sv ====
`timescale 1ns/1ps

module fc_obi_axil_bridge (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  fc_pkg::obi_req_t  req_i,
  output logic              req_pop_o,
  input  logic              rsp_full_i,
  output logic              rsp_push_o,
  output fc_pkg::obi_rsp_t  rsp_o,
  output fc_pkg::axil_req_t axil_req_o,
  input  fc_pkg::axil_rsp_t axil_rsp_i
);

  import fc_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StWrAddrData,
    StWrResp,
    StRd
  } state_e;

  state_e   state_q;
  obi_req_t req_q;
  logic     aw_done_q;
  logic     w_done_q;
  logic     ar_done_q;
  logic     aw_hs;
  logic     w_hs;
  logic     ar_hs;
  logic     b_hs;
  logic     r_hs;

  //**************************************************
  // AXI4-Lite channel drive
  //**************************************************

  assign axil_req_o.aw_valid = (state_q == StWrAddrData) & ~aw_done_q;
  assign axil_req_o.aw_addr  = req_q.addr;
  assign axil_req_o.w_valid  = (state_q == StWrAddrData) & ~w_done_q;
  assign axil_req_o.w_data   = req_q.wdata;
  assign axil_req_o.w_strb   = req_q.be;
  assign axil_req_o.b_ready  = (state_q == StWrResp);
  assign axil_req_o.ar_valid = (state_q == StRd) & ~ar_done_q;
  assign axil_req_o.ar_addr  = req_q.addr;
  assign axil_req_o.r_ready  = (state_q == StRd);

  assign aw_hs = axil_req_o.aw_valid & axil_rsp_i.aw_ready;
  assign w_hs  = axil_req_o.w_valid & axil_rsp_i.w_ready;
  assign ar_hs = axil_req_o.ar_valid & axil_rsp_i.ar_ready;
  assign b_hs  = axil_req_o.b_ready & axil_rsp_i.b_valid;
  assign r_hs  = axil_req_o.r_ready & axil_rsp_i.r_valid;

  // Start a new transfer only with room for its response
  assign req_pop_o = (state_q == StIdle) & req_valid_i & ~rsp_full_i;

  //**************************************************
  // Core response
  //**************************************************

  assign rsp_push_o = b_hs | r_hs;

  always_comb begin
    if (state_q == StRd) begin
      rsp_o.rdata = axil_rsp_i.r_data;
      rsp_o.err   = (axil_rsp_i.r_resp != AxiRespOkay);
    end else begin
      rsp_o.rdata = '0;
      rsp_o.err   = (axil_rsp_i.b_resp != AxiRespOkay);
    end
  end

  //**************************************************
  // Transfer FSM
  //**************************************************

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= StIdle;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      ar_done_q <= 1'b0;
    end else begin
      case (state_q)
        StIdle: begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          ar_done_q <= 1'b0;
          if (req_pop_o) begin
            state_q <= req_i.we ? StWrAddrData : StRd;
          end
        end
        StWrAddrData: begin
          // AW and W may finish in either order
          if (aw_hs) aw_done_q <= 1'b1;
          if (w_hs) w_done_q <= 1'b1;
          if ((aw_done_q | aw_hs) && (w_done_q | w_hs)) begin
            state_q <= StWrResp;
          end
        end
        StWrResp: begin
          if (b_hs) state_q <= StIdle;
        end
        StRd: begin
          if (ar_hs) ar_done_q <= 1'b1;
          if (r_hs) state_q <= StIdle;
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Popped request held for stable AXI outputs
  always_ff @(posedge clk_i) begin
    if (req_pop_o) begin
      req_q <= req_i;
    end
  end

endmodule

// ==== hdl/fc_subsystem.sv ====
`timescale 1ns/1ps

module fc_subsystem #(
  parameter int unsigned BufDepth = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // Core data port
  input  logic                          req_i,
  input  fc_pkg::obi_req_t              obi_req_i,
  output logic                          gnt_o,
  output logic                          rvalid_o,
  output fc_pkg::obi_rsp_t              obi_rsp_o,

  // AXI4-Lite toward L2
  output fc_pkg::axil_req_t             axil_req_o,
  input  fc_pkg::axil_rsp_t             axil_rsp_i,

  // Interrupts
  input  logic [fc_pkg::NumIrq-1:0]     events_i,
  input  logic                          irq_ack_i,
  input  logic [fc_pkg::IrqIdWidth-1:0] irq_ack_id_i,
  output logic                          irq_req_o,
  output logic [fc_pkg::IrqIdWidth-1:0] irq_id_o
);

  import fc_pkg::*;

  logic     req_full;
  logic     req_valid;
  logic     req_pop;
  obi_req_t req_head;
  logic     rsp_full;
  logic     rsp_push;
  obi_rsp_t rsp_data;

  // Grant whenever the request buffer has room
  assign gnt_o = req_i & ~req_full;

  //**************************************************
  // Request buffer
  //**************************************************

  fc_buffer #(
    .payload_t(obi_req_t),
    .BufDepth (BufDepth)
  ) req_buffer_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (gnt_o),
    .data_i (obi_req_i),
    .full_o (req_full),
    .pop_i  (req_pop),
    .data_o (req_head),
    .valid_o(req_valid)
  );

  fc_obi_axil_bridge bridge_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_valid_i(req_valid),
    .req_i      (req_head),
    .req_pop_o  (req_pop),
    .rsp_full_i (rsp_full),
    .rsp_push_o (rsp_push),
    .rsp_o      (rsp_data),
    .axil_req_o (axil_req_o),
    .axil_rsp_i (axil_rsp_i)
  );

  //**************************************************
  // Response buffer
  //**************************************************

  // Core never stalls the response, so the head leaves every valid cycle
  fc_buffer #(
    .payload_t(obi_rsp_t),
    .BufDepth (BufDepth)
  ) rsp_buffer_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (rsp_push),
    .data_i (rsp_data),
    .full_o (rsp_full),
    .pop_i  (rvalid_o),
    .data_o (obi_rsp_o),
    .valid_o(rvalid_o)
  );

  fc_irq_ctrl irq_ctrl_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .events_i    (events_i),
    .irq_ack_i   (irq_ack_i),
    .irq_ack_id_i(irq_ack_id_i),
    .irq_req_o   (irq_req_o),
    .irq_id_o    (irq_id_o)
  );

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 8,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset leaves on a falling edge, clear of the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== dv/tb_fc_subsystem.sv ====
`timescale 1ns/1ps

module tb_fc_subsystem;

  import fc_pkg::*;

  localparam int unsigned BufDepth    = 2;
  localparam int unsigned CyclesPerOp = 64;

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  obi_req_t              obi_req;
  logic                  gnt;
  logic                  rvalid;
  obi_rsp_t              obi_rsp;
  axil_req_t             axil_req;
  axil_rsp_t             axil_rsp;
  logic [NumIrq-1:0]     events;
  logic                  irq_ack;
  logic [IrqIdWidth-1:0] irq_ack_id;
  logic                  irq_req;
  logic [IrqIdWidth-1:0] irq_id;

  // Stimulus columns
  logic [7:0]  op_q[$];
  logic [31:0] arg_q[$];
  logic [31:0] data_q[$];
  logic [31:0] sel_q[$];
  logic [31:0] res_q[$];

  // Expected core responses in issue order
  logic        exp_err_q[$];
  logic [31:0] exp_rdata_q[$];

  logic [31:0] mem [64];
  int          seed = 78524;
  int unsigned grant_cnt = 0;
  int unsigned start_cnt = 0;
  int unsigned rsp_cnt = 0;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;
  logic        busy_q = 1'b0;
  logic        aw_seen;
  logic        w_seen;
  logic        ar_seen;
  logic        b_hs_next;
  logic        r_hs_next;
  logic [31:0] aw_addr;
  logic [31:0] ar_addr;
  logic [31:0] w_data;
  logic [3:0]  w_strb;

  tb_clk_gen #(
    .PeriodNs   (8),
    .ResetCycles(8)
  ) clk_gen_i (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  fc_subsystem #(
    .BufDepth(BufDepth)
  ) fc_subsystem_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_i       (req),
    .obi_req_i   (obi_req),
    .gnt_o       (gnt),
    .rvalid_o    (rvalid),
    .obi_rsp_o   (obi_rsp),
    .axil_req_o  (axil_req),
    .axil_rsp_i  (axil_rsp),
    .events_i    (events),
    .irq_ack_i   (irq_ack),
    .irq_ack_id_i(irq_ack_id),
    .irq_req_o   (irq_req),
    .irq_id_o    (irq_id)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      fail_run($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, want));
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  f_op;
    logic [31:0] f_arg;
    logic [31:0] f_data;
    logic [31:0] f_sel;
    logic [31:0] f_res;
    fd = $fopen("dv/fc_stimulus.txt", "r");
    if (fd == 0) begin
      fail_run("Cannot open the stimulus file dv/fc_stimulus.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h %h %h", f_op, f_arg, f_data, f_sel, f_res);
          if (n == 5) begin
            op_q.push_back(f_op);
            arg_q.push_back(f_arg);
            data_q.push_back(f_data);
            sel_q.push_back(f_sel);
            res_q.push_back(f_res);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Starts at a falling edge and returns at the falling edge after the grant
  task automatic issue_request(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] be,
                               input logic err, input logic [31:0] rdata);
    logic granted;
    granted       = 1'b0;
    req           = 1'b1;
    obi_req.addr  = addr;
    obi_req.we    = we;
    obi_req.be    = be;
    obi_req.wdata = wdata;
    while (!granted) begin
      #1;
      // Request buffer holds what was granted and not yet started on AXI
      check("gnt_o", 32'(gnt), 32'((grant_cnt - start_cnt) < BufDepth));
      granted = gnt;
      if (granted) begin
        exp_err_q.push_back(err);
        exp_rdata_q.push_back(rdata);
        grant_cnt++;
      end
      @(negedge clk);
    end
  endtask

  task automatic drain_responses();
    req = 1'b0;
    while (rsp_cnt != grant_cnt) @(posedge clk);
    @(negedge clk);
  endtask

  //**************************************************
  // Core side and interrupt driver
  //**************************************************

  initial begin
    req        = 1'b0;
    obi_req    = '0;
    events     = '0;
    irq_ack    = 1'b0;
    irq_ack_id = '0;
    load_stimulus();
    cycle_limit = CyclesPerOp * op_q.size();
    @(posedge rst_n);
    @(negedge clk);
    check("rvalid_o", 32'(rvalid), 32'h0);
    check("irq_req_o", 32'(irq_req), 32'h0);
    check("axi valids", 32'(axil_req.aw_valid | axil_req.w_valid | axil_req.ar_valid), 32'h0);
    for (int i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        "W": issue_request(1'b1, arg_q[i], data_q[i], sel_q[i][3:0], res_q[i][0], '0);
        "R": issue_request(1'b0, arg_q[i], '0, 4'hf, sel_q[i][0], res_q[i]);
        "E", "A": begin
          drain_responses();
          irq_ack    = (op_q[i] == "A");
          irq_ack_id = arg_q[i][4:0];
          events     = (op_q[i] == "A") ? data_q[i] : arg_q[i];
          @(negedge clk);
          irq_ack = 1'b0;
          events  = '0;
          #1;
          check("irq_req_o", 32'(irq_req), 32'(sel_q[i][0]));
          check("irq_id_o", 32'(irq_id), 32'(res_q[i][4:0]));
          @(negedge clk);
        end
        default: fail_run($sformatf("Unknown operation on stimulus line %0d", i));
      endcase
    end
    drain_responses();
    $display("NO ERRORS");
    $finish;
  end

  //**************************************************
  // AXI4-Lite L2 slave model
  //**************************************************

  initial begin
    axil_rsp  = '0;
    aw_seen   = 1'b0;
    w_seen    = 1'b0;
    ar_seen   = 1'b0;
    b_hs_next = 1'b0;
    r_hs_next = 1'b0;
    for (int i = 0; i < 64; i++) begin
      mem[i[5:0]] = 32'h1000_0000 | 32'(i << 2);
    end
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (b_hs_next) axil_rsp.b_valid = 1'b0;
        if (r_hs_next) axil_rsp.r_valid = 1'b0;
        // Answer only transfers accepted at an earlier edge
        if (aw_seen && w_seen && !axil_rsp.b_valid && ($random(seed) & 1)) begin
          if (!aw_addr[31]) begin
            for (int b = 0; b < 4; b++) begin
              if (w_strb[b]) mem[aw_addr[7:2]][8*b +: 8] = w_data[8*b +: 8];
            end
          end
          axil_rsp.b_resp  = aw_addr[31] ? AxiRespSlvErr : AxiRespOkay;
          axil_rsp.b_valid = 1'b1;
          aw_seen          = 1'b0;
          w_seen           = 1'b0;
        end
        if (ar_seen && !axil_rsp.r_valid && ($random(seed) & 1)) begin
          axil_rsp.r_data  = ar_addr[31] ? '0 : mem[ar_addr[7:2]];
          axil_rsp.r_resp  = ar_addr[31] ? AxiRespSlvErr : AxiRespOkay;
          axil_rsp.r_valid = 1'b1;
          ar_seen          = 1'b0;
        end
        axil_rsp.aw_ready = ($random(seed) & 3) != 0;
        axil_rsp.w_ready  = ($random(seed) & 3) != 0;
        axil_rsp.ar_ready = ($random(seed) & 3) != 0;
        // Handshakes that the next rising edge completes
        if (axil_req.aw_valid && axil_rsp.aw_ready) begin
          aw_seen = 1'b1;
          aw_addr = axil_req.aw_addr;
        end
        if (axil_req.w_valid && axil_rsp.w_ready) begin
          w_seen = 1'b1;
          w_data = axil_req.w_data;
          w_strb = axil_req.w_strb;
        end
        if (axil_req.ar_valid && axil_rsp.ar_ready) begin
          ar_seen = 1'b1;
          ar_addr = axil_req.ar_addr;
        end
        b_hs_next = axil_rsp.b_valid & axil_req.b_ready;
        r_hs_next = axil_rsp.r_valid & axil_req.r_ready;
      end
    end
  end

  // Transfer starts and core responses
  always @(negedge clk) begin
    if (rst_n) begin
      if ((axil_req.aw_valid | axil_req.w_valid | axil_req.ar_valid) && !busy_q) start_cnt++;
      busy_q = axil_req.aw_valid | axil_req.w_valid | axil_req.ar_valid;
      if (rvalid) begin
        if (exp_err_q.size() == 0) begin
          fail_run("Response on rvalid_o with no request outstanding");
        end else begin
          check("obi_rsp_o.err", 32'(obi_rsp.err), 32'(exp_err_q.pop_front()));
          check("obi_rsp_o.rdata", obi_rsp.rdata, exp_rdata_q.pop_front());
          rsp_cnt++;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycle_cnt++;
      if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
        fail_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
      end
    end
  end

endmodule

// ==== compile.f ====
hdl/fc_pkg.sv
hdl/fc_buffer.sv
hdl/fc_irq_ctrl.sv
hdl/fc_obi_axil_bridge.sv
hdl/fc_subsystem.sv
dv/tb_clk_gen.sv
dv/tb_fc_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the result

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_fc_subsystem -f compile.f -o tb_fc_subsystem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_fc_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== dv/fc_stimulus.txt ====
# op arg data sel res, all hex. W: addr wdata strobe err | R: addr 0 err rdata
# E: event_mask 0 irq_req irq_id | A: ack_id event_mask irq_req irq_id
R 00000010 00000000 0 10000010
W 00000010 aabbccdd 5 0
R 00000010 00000000 0 10bb00dd
W 00000020 12345678 f 0
R 00000020 00000000 0 12345678
W 00000024 cafef00d c 0
R 00000024 00000000 0 cafe0024
W 80000010 deadbeef f 1
R 80000010 00000000 1 00000000
R 00000010 00000000 0 10bb00dd
W 00000040 00000001 f 0
W 00000044 00000002 3 0
W 00000048 00000003 f 0
R 00000040 00000000 0 00000001
R 00000044 00000000 0 10000002
R 00000048 00000000 0 00000003
R 0000004c 00000000 0 1000004c
R 800000fc 00000000 1 00000000
E 00010a00 00000000 1 09
A 00000009 00000000 1 0b
E 00000004 00000000 1 02
A 00000002 00000000 1 0b
A 0000000b 00000000 1 10
A 00000010 00000000 0 00
A 00000005 00000020 0 00
A 00000003 00000021 1 00
A 00000000 00000000 1 05
A 00000005 00000000 0 00
W 000000fc 0000beef f 0
R 000000fc 00000000 0 0000beef
